/* source/ex_pkg.sv */
/*
 * execute stage package
 * widths, word types, control enums and reset values shared by the scalar
 * execute datapath and its pipeline register
 */
package ex_pkg;

    // datapath and register index widths
    localparam int XLEN      = 32;
    localparam int REG_IDX_W = 5;

    typedef logic [XLEN-1:0]      word_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;

    // raw immediate field widths as delivered by decode
    localparam int IMM_I_W  = 12;
    localparam int IMM_S_W  = 12;
    localparam int IMM_SB_W = 13;
    localparam int IMM_UJ_W = 21;
    localparam int SHAMT_W  = 5;

    // sequential fall-through increment
    localparam word_t PC_STEP = 32'd4;

    // values loaded on reset and on flush
    localparam word_t    RST_WORD = '0;
    localparam reg_idx_t RST_IDX  = '0;
    localparam logic     RST_BIT  = 1'b0;

    // alu operations, shifts take the low bits of port b
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLT  = 4'd5,
        ALU_SLTU = 4'd6,
        ALU_SLL  = 4'd7,
        ALU_SRL  = 4'd8,
        ALU_SRA  = 4'd9
    } alu_op_t;

    // conditional branch kinds
    typedef enum logic [2:0] {
        BR_NONE = 3'd0,
        BR_EQ   = 3'd1,
        BR_NE   = 3'd2,
        BR_LT   = 3'd3,
        BR_GE   = 3'd4,
        BR_LTU  = 3'd5,
        BR_GEU  = 3'd6
    } branch_t;

    // operand a source
    typedef enum logic [1:0] {
        A_RS1   = 2'd0,
        A_IMM_S = 2'd1,
        A_PC    = 2'd2,
        A_ZERO  = 2'd3
    } alu_a_sel_t;

    // operand b source
    typedef enum logic [1:0] {
        B_RS1       = 2'd0,
        B_RS2       = 2'd1,
        B_IMM_SHAMT = 2'd2,
        B_IMM_U     = 2'd3
    } alu_b_sel_t;

endpackage

/* source/operand_if.sv */
/*
 * operand bundle from operand selection to the compute unit
 * forwarded register values, alu operands and extended immediates
 */
`timescale 1ns/1ps

interface operand_if;

    // alu operands after source selection
    ex_pkg::word_t port_a;
    ex_pkg::word_t port_b;

    // register values after forwarding
    ex_pkg::word_t rs1_val;
    ex_pkg::word_t rs2_val;

    // sign-extended immediates used for targets
    ex_pkg::word_t imm_i_ext;
    ex_pkg::word_t imm_uj_ext;
    ex_pkg::word_t imm_sb_ext;

    modport producer (
        output port_a, port_b, rs1_val, rs2_val, imm_i_ext, imm_uj_ext, imm_sb_ext
    );

    modport consumer (
        input port_a, port_b, rs1_val, rs2_val, imm_i_ext, imm_uj_ext, imm_sb_ext
    );

endinterface

/* source/ex_operand_sel.sv */
/*
 * execute operand selection
 * forwards memory-stage data onto rs1/rs2, sign-extends the immediates
 * and picks the two alu operands
 */
`timescale 1ns/1ps

module ex_operand_sel (
    input  ex_pkg::word_t                  pc,
    input  ex_pkg::word_t                  rs1_data,
    input  ex_pkg::word_t                  rs2_data,
    input  ex_pkg::word_t                  rd_mem_data,
    input  logic                           fwd_rs1,
    input  logic                           fwd_rs2,
    input  logic [ex_pkg::IMM_I_W-1:0]     imm_i,
    input  logic [ex_pkg::IMM_S_W-1:0]     imm_s,
    input  logic [ex_pkg::IMM_SB_W-1:0]    imm_sb,
    input  logic [ex_pkg::IMM_UJ_W-1:0]    imm_uj,
    input  logic [ex_pkg::SHAMT_W-1:0]     shamt,
    input  ex_pkg::word_t                  imm_u,
    input  logic                           imm_shamt_sel,
    input  ex_pkg::alu_a_sel_t             alu_a_sel,
    input  ex_pkg::alu_b_sel_t             alu_b_sel,
    operand_if.producer                    op
);

    ex_pkg::word_t imm_s_ext;
    ex_pkg::word_t imm_or_shamt;

    // memory-stage bypass
    assign op.rs1_val = fwd_rs1 ? rd_mem_data : rs1_data;
    assign op.rs2_val = fwd_rs2 ? rd_mem_data : rs2_data;

    // replicate the top bit of each field up to a full word
    assign op.imm_i_ext  = {{(ex_pkg::XLEN-ex_pkg::IMM_I_W){imm_i[ex_pkg::IMM_I_W-1]}}, imm_i};
    assign imm_s_ext     = {{(ex_pkg::XLEN-ex_pkg::IMM_S_W){imm_s[ex_pkg::IMM_S_W-1]}}, imm_s};
    assign op.imm_sb_ext = {{(ex_pkg::XLEN-ex_pkg::IMM_SB_W){imm_sb[ex_pkg::IMM_SB_W-1]}},
                            imm_sb};
    assign op.imm_uj_ext = {{(ex_pkg::XLEN-ex_pkg::IMM_UJ_W){imm_uj[ex_pkg::IMM_UJ_W-1]}},
                            imm_uj};

    // shift amount is unsigned, zero-filled
    assign imm_or_shamt = imm_shamt_sel ? {{(ex_pkg::XLEN-ex_pkg::SHAMT_W){1'b0}}, shamt}
                                        : op.imm_i_ext;

    // operand a
    always_comb begin
        case (alu_a_sel)
            ex_pkg::A_RS1:   op.port_a = op.rs1_val;
            ex_pkg::A_IMM_S: op.port_a = imm_s_ext;
            ex_pkg::A_PC:    op.port_a = pc;
            default:         op.port_a = '0;
        endcase
    end

    // operand b
    always_comb begin
        case (alu_b_sel)
            ex_pkg::B_RS1:       op.port_b = op.rs1_val;
            ex_pkg::B_RS2:       op.port_b = op.rs2_val;
            ex_pkg::B_IMM_SHAMT: op.port_b = imm_or_shamt;
            default:             op.port_b = imm_u;
        endcase
    end

endmodule

/* source/ex_compute.sv */
/*
 * execute compute unit
 * alu, branch condition, jump and branch targets, next-pc selection
 */
`timescale 1ns/1ps

module ex_compute (
    operand_if.consumer        op,
    input  ex_pkg::word_t      pc,
    input  ex_pkg::alu_op_t    alu_op,
    input  ex_pkg::branch_t    branch_type,
    input  logic               j_sel,
    input  logic               ex_pc_sel,
    output ex_pkg::word_t      result,
    output ex_pkg::word_t      brj_addr,
    output logic               branch_taken
);

    logic [ex_pkg::SHAMT_W-1:0] shift_amt;
    logic                       alu_lt;
    logic                       alu_ltu;

    logic                       br_eq;
    logic                       br_lt;
    logic                       br_ltu;

    ex_pkg::word_t              jalr_sum;
    ex_pkg::word_t              jump_addr;
    ex_pkg::word_t              branch_addr;
    ex_pkg::word_t              pc_next;
    ex_pkg::word_t              resolved_addr;

    // alu

    assign shift_amt = op.port_b[ex_pkg::SHAMT_W-1:0];
    assign alu_lt    = $signed(op.port_a) < $signed(op.port_b);
    assign alu_ltu   = op.port_a < op.port_b;

    always_comb begin
        case (alu_op)
            ex_pkg::ALU_ADD:  result = op.port_a + op.port_b;
            ex_pkg::ALU_SUB:  result = op.port_a - op.port_b;
            ex_pkg::ALU_AND:  result = op.port_a & op.port_b;
            ex_pkg::ALU_OR:   result = op.port_a | op.port_b;
            ex_pkg::ALU_XOR:  result = op.port_a ^ op.port_b;
            ex_pkg::ALU_SLT:  result = {{(ex_pkg::XLEN-1){1'b0}}, alu_lt};
            ex_pkg::ALU_SLTU: result = {{(ex_pkg::XLEN-1){1'b0}}, alu_ltu};
            ex_pkg::ALU_SLL:  result = op.port_a << shift_amt;
            ex_pkg::ALU_SRL:  result = op.port_a >> shift_amt;
            ex_pkg::ALU_SRA:  result = ex_pkg::word_t'($signed(op.port_a) >>> shift_amt);
            default:          result = '0;
        endcase
    end

    // branch condition on the forwarded register values

    assign br_eq  = op.rs1_val == op.rs2_val;
    assign br_lt  = $signed(op.rs1_val) < $signed(op.rs2_val);
    assign br_ltu = op.rs1_val < op.rs2_val;

    always_comb begin
        case (branch_type)
            ex_pkg::BR_EQ:  branch_taken = br_eq;
            ex_pkg::BR_NE:  branch_taken = !br_eq;
            ex_pkg::BR_LT:  branch_taken = br_lt;
            ex_pkg::BR_GE:  branch_taken = !br_lt;
            ex_pkg::BR_LTU: branch_taken = br_ltu;
            ex_pkg::BR_GEU: branch_taken = !br_ltu;
            // BR_NONE never branches
            default:        branch_taken = 1'b0;
        endcase
    end

    // targets

    // jalr base is the register, lsb dropped per the isa
    assign jalr_sum  = op.rs1_val + op.imm_i_ext;
    assign jump_addr = j_sel ? (pc + op.imm_uj_ext)
                             : {jalr_sum[ex_pkg::XLEN-1:1], 1'b0};

    assign branch_addr = pc + op.imm_sb_ext;

    // sequential fall-through
    assign pc_next = pc + ex_pkg::PC_STEP;

    assign resolved_addr = branch_taken ? branch_addr : pc_next;

    // jumps override the branch outcome
    assign brj_addr = ex_pc_sel ? jump_addr : resolved_addr;

endmodule

/* source/ex_mem_reg.sv */
/*
 * execute/memory pipeline register
 * loads each cycle, clears on flush, holds on stall, squashes control
 * bits of illegal instructions
 */
`timescale 1ns/1ps

module ex_mem_reg (
    input  logic              CLK,
    input  logic              nRST,
    input  logic              ex_mem_stall,
    input  logic              ex_mem_flush,
    input  logic              valid,
    input  logic              reg_write,
    input  logic              illegal_insn,
    input  ex_pkg::reg_idx_t  rd,
    input  ex_pkg::word_t     pc,
    input  ex_pkg::word_t     result,
    input  ex_pkg::word_t     brj_addr,
    input  logic              branch_taken,
    output logic              mem_valid,
    output logic              mem_reg_write,
    output ex_pkg::reg_idx_t  mem_rd,
    output ex_pkg::word_t     mem_result,
    output ex_pkg::word_t     mem_brj_addr,
    output ex_pkg::word_t     mem_pc,
    output logic              mem_branch_taken,
    output logic              mem_illegal_insn
);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            mem_valid        <= ex_pkg::RST_BIT;
            mem_reg_write    <= ex_pkg::RST_BIT;
            mem_rd           <= ex_pkg::RST_IDX;
            mem_result       <= ex_pkg::RST_WORD;
            mem_brj_addr     <= ex_pkg::RST_WORD;
            mem_pc           <= ex_pkg::RST_WORD;
            mem_branch_taken <= ex_pkg::RST_BIT;
            mem_illegal_insn <= ex_pkg::RST_BIT;
        end else if (ex_mem_stall) begin
            // back-pressure, hold everything even if a flush is pending
        end else if (ex_mem_flush) begin
            // bubble into the memory stage
            mem_valid        <= ex_pkg::RST_BIT;
            mem_reg_write    <= ex_pkg::RST_BIT;
            mem_rd           <= ex_pkg::RST_IDX;
            mem_result       <= ex_pkg::RST_WORD;
            mem_brj_addr     <= ex_pkg::RST_WORD;
            mem_pc           <= ex_pkg::RST_WORD;
            mem_branch_taken <= ex_pkg::RST_BIT;
            mem_illegal_insn <= ex_pkg::RST_BIT;
        end else begin
            mem_valid        <= valid;
            // illegal instructions must not write back or redirect
            mem_reg_write    <= reg_write && !illegal_insn;
            mem_branch_taken <= branch_taken && !illegal_insn;
            mem_illegal_insn <= illegal_insn;
            mem_rd           <= rd;
            mem_result       <= result;
            mem_brj_addr     <= brj_addr;
            mem_pc           <= pc;
        end
    end

endmodule

/* source/ex_stage_top.sv */
/*
 * scalar execute stage top
 * operand selection feeding the compute unit, captured in the ex/mem register
 */
`timescale 1ns/1ps

module ex_stage_top (
    input  logic                           CLK,
    input  logic                           nRST,
    input  logic                           valid,
    input  ex_pkg::word_t                  pc,
    input  ex_pkg::word_t                  rs1_data,
    input  ex_pkg::word_t                  rs2_data,
    input  ex_pkg::word_t                  rd_mem_data,
    input  logic                           fwd_rs1,
    input  logic                           fwd_rs2,
    input  logic [ex_pkg::IMM_I_W-1:0]     imm_i,
    input  logic [ex_pkg::IMM_S_W-1:0]     imm_s,
    input  logic [ex_pkg::IMM_SB_W-1:0]    imm_sb,
    input  logic [ex_pkg::IMM_UJ_W-1:0]    imm_uj,
    input  logic [ex_pkg::SHAMT_W-1:0]     shamt,
    input  ex_pkg::word_t                  imm_u,
    input  logic                           imm_shamt_sel,
    input  ex_pkg::alu_a_sel_t             alu_a_sel,
    input  ex_pkg::alu_b_sel_t             alu_b_sel,
    input  ex_pkg::alu_op_t                alu_op,
    input  ex_pkg::branch_t                branch_type,
    input  logic                           j_sel,
    input  logic                           ex_pc_sel,
    input  logic                           reg_write,
    input  ex_pkg::reg_idx_t               rd,
    input  logic                           illegal_insn,
    input  logic                           ex_mem_stall,
    input  logic                           ex_mem_flush,
    output logic                           mem_valid,
    output logic                           mem_reg_write,
    output ex_pkg::reg_idx_t               mem_rd,
    output ex_pkg::word_t                  mem_result,
    output ex_pkg::word_t                  mem_brj_addr,
    output ex_pkg::word_t                  mem_pc,
    output logic                           mem_branch_taken,
    output logic                           mem_illegal_insn
);

    // compute results into the pipeline register
    ex_pkg::word_t result;
    ex_pkg::word_t brj_addr;
    logic          branch_taken;

    operand_if op_if ();

    ex_operand_sel u_operand_sel (
        .pc, .rs1_data, .rs2_data, .rd_mem_data, .fwd_rs1, .fwd_rs2,
        .imm_i, .imm_s, .imm_sb, .imm_uj, .shamt, .imm_u, .imm_shamt_sel,
        .alu_a_sel, .alu_b_sel,
        .op (op_if.producer)
    );

    ex_compute u_compute (
        .op (op_if.consumer),
        .pc, .alu_op, .branch_type, .j_sel, .ex_pc_sel,
        .result, .brj_addr, .branch_taken
    );

    // per-instruction controls bypass the datapath blocks
    ex_mem_reg u_mem_reg (
        .CLK, .nRST, .ex_mem_stall, .ex_mem_flush,
        .valid, .reg_write, .illegal_insn, .rd, .pc,
        .result, .brj_addr, .branch_taken,
        .mem_valid, .mem_reg_write, .mem_rd, .mem_result, .mem_brj_addr,
        .mem_pc, .mem_branch_taken, .mem_illegal_insn
    );

endmodule

/* test/ex_stage_props.sv */
/*
 * ex/mem register properties
 * flush clears valid, stall holds all outputs, illegal never writes back
 */
`timescale 1ns/1ps

module ex_stage_props (
    input logic              CLK,
    input logic              nRST,
    input logic              ex_mem_stall,
    input logic              ex_mem_flush,
    input logic              mem_valid,
    input logic              mem_reg_write,
    input ex_pkg::reg_idx_t  mem_rd,
    input ex_pkg::word_t     mem_result,
    input ex_pkg::word_t     mem_brj_addr,
    input ex_pkg::word_t     mem_pc,
    input logic              mem_branch_taken,
    input logic              mem_illegal_insn
);

    // flush alone inserts a bubble
    a_flush_clears: assert property (@(posedge CLK) disable iff (!nRST)
        (ex_mem_flush && !ex_mem_stall) |=> !mem_valid)
        else $error("flush without stall left mem_valid set");

    // stall freezes the register, flush or not
    a_stall_holds: assert property (@(posedge CLK) disable iff (!nRST)
        ex_mem_stall |=> ($stable(mem_valid) && $stable(mem_reg_write) &&
                          $stable(mem_rd) && $stable(mem_result) &&
                          $stable(mem_brj_addr) && $stable(mem_pc) &&
                          $stable(mem_branch_taken) && $stable(mem_illegal_insn)))
        else $error("stall did not hold the ex/mem register");

    a_illegal_no_write: assert property (@(posedge CLK) disable iff (!nRST)
        !(mem_reg_write && mem_illegal_insn))
        else $error("illegal instruction reached memory with reg_write set");

endmodule

bind ex_mem_reg ex_stage_props u_props (.*);

/* test/ex_stage_tb.sv */
/*
 * execute stage testbench
 * table-driven stimulus through the DUT with checks on every mem_ output
 */
`timescale 1ns/1ps

module ex_stage_tb;

    // one table row, inputs first then the expected register contents
    typedef struct packed {
        ex_pkg::word_t                pc;
        ex_pkg::word_t                rs1;
        ex_pkg::word_t                rs2;
        ex_pkg::word_t                rd_mem;
        logic                         fwd1;
        logic                         fwd2;
        logic [ex_pkg::IMM_I_W-1:0]   imm_i;
        logic [ex_pkg::IMM_S_W-1:0]   imm_s;
        logic [ex_pkg::IMM_SB_W-1:0]  imm_sb;
        logic [ex_pkg::IMM_UJ_W-1:0]  imm_uj;
        logic [ex_pkg::SHAMT_W-1:0]   shamt;
        ex_pkg::word_t                imm_u;
        logic                         shamt_sel;
        ex_pkg::alu_a_sel_t           a_sel;
        ex_pkg::alu_b_sel_t           b_sel;
        ex_pkg::alu_op_t              op;
        ex_pkg::branch_t              br;
        logic                         j_sel;
        logic                         pc_sel;
        logic                         reg_write;
        ex_pkg::reg_idx_t             rd;
        logic                         illegal;
        logic                         stall;
        logic                         flush;
        logic                         valid;
        logic                         e_valid;
        logic                         e_reg_write;
        ex_pkg::reg_idx_t             e_rd;
        ex_pkg::word_t                e_result;
        ex_pkg::word_t                e_brj;
        ex_pkg::word_t                e_pc;
        logic                         e_taken;
        logic                         e_illegal;
    } vec_t;

    logic                          CLK;
    logic                          nRST;
    logic                          valid;
    ex_pkg::word_t                 pc;
    ex_pkg::word_t                 rs1_data;
    ex_pkg::word_t                 rs2_data;
    ex_pkg::word_t                 rd_mem_data;
    logic                          fwd_rs1;
    logic                          fwd_rs2;
    logic [ex_pkg::IMM_I_W-1:0]    imm_i;
    logic [ex_pkg::IMM_S_W-1:0]    imm_s;
    logic [ex_pkg::IMM_SB_W-1:0]   imm_sb;
    logic [ex_pkg::IMM_UJ_W-1:0]   imm_uj;
    logic [ex_pkg::SHAMT_W-1:0]    shamt;
    ex_pkg::word_t                 imm_u;
    logic                          imm_shamt_sel;
    ex_pkg::alu_a_sel_t            alu_a_sel;
    ex_pkg::alu_b_sel_t            alu_b_sel;
    ex_pkg::alu_op_t               alu_op;
    ex_pkg::branch_t               branch_type;
    logic                          j_sel;
    logic                          ex_pc_sel;
    logic                          reg_write;
    ex_pkg::reg_idx_t              rd;
    logic                          illegal_insn;
    logic                          ex_mem_stall;
    logic                          ex_mem_flush;
    logic                          mem_valid;
    logic                          mem_reg_write;
    ex_pkg::reg_idx_t              mem_rd;
    ex_pkg::word_t                 mem_result;
    ex_pkg::word_t                 mem_brj_addr;
    ex_pkg::word_t                 mem_pc;
    logic                          mem_branch_taken;
    logic                          mem_illegal_insn;

    vec_t  table_q[$];
    string names_q[$];

    ex_stage_top DUT (.*);

    initial begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;
    end

    // reset held for five cycles
    initial begin
        nRST = 1'b0;
        repeat (5) @(posedge CLK);
        nRST <= 1'b1;
    end

    // plain add of rs1 and rs2, falls through to pc + 4
    function automatic vec_t base_vec(input ex_pkg::word_t pc_val);
        vec_t v;
        v = '0;
        v.pc          = pc_val;
        v.a_sel       = ex_pkg::A_RS1;
        v.b_sel       = ex_pkg::B_RS2;
        v.op          = ex_pkg::ALU_ADD;
        v.br          = ex_pkg::BR_NONE;
        v.valid       = 1'b1;
        v.reg_write   = 1'b1;
        v.rd          = 5'd5;
        v.e_valid     = 1'b1;
        v.e_reg_write = 1'b1;
        v.e_rd        = 5'd5;
        v.e_pc        = pc_val;
        v.e_brj       = pc_val + 32'd4;
        return v;
    endfunction

    // register-register alu row at pc 0x100
    function automatic vec_t alu_vec(input ex_pkg::alu_op_t op, input ex_pkg::word_t rs1,
                                     input ex_pkg::word_t rs2, input ex_pkg::word_t res);
        vec_t v;
        v = base_vec(32'h100);
        v.op       = op;
        v.rs1      = rs1;
        v.rs2      = rs2;
        v.e_result = res;
        return v;
    endfunction

    // conditional branch at pc 0x200, alu adds rs1 and rs2
    function automatic vec_t branch_vec(input ex_pkg::branch_t br, input ex_pkg::word_t rs1,
                                        input ex_pkg::word_t rs2,
                                        input logic [ex_pkg::IMM_SB_W-1:0] sb,
                                        input ex_pkg::word_t sum, input logic taken,
                                        input ex_pkg::word_t target);
        vec_t v;
        v = base_vec(32'h200);
        v.br       = br;
        v.rs1      = rs1;
        v.rs2      = rs2;
        v.imm_sb   = sb;
        v.e_result = sum;
        v.e_taken  = taken;
        v.e_brj    = target;
        return v;
    endfunction

    task automatic add_entry(input string name, input vec_t v);
        names_q.push_back(name);
        table_q.push_back(v);
    endtask

    task automatic check(input string name, input string field,
                         input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("CHECK FAILED %s %s: expected %h actual %h", name, field, exp, act);
            $display("Test failed");
            $fatal(1, "mismatch");
        end
    endtask

    task automatic check_outputs(input string name, input vec_t v);
        check(name, "mem_valid", 32'(v.e_valid), 32'(mem_valid));
        check(name, "mem_reg_write", 32'(v.e_reg_write), 32'(mem_reg_write));
        check(name, "mem_rd", 32'(v.e_rd), 32'(mem_rd));
        check(name, "mem_result", v.e_result, mem_result);
        check(name, "mem_brj_addr", v.e_brj, mem_brj_addr);
        check(name, "mem_pc", v.e_pc, mem_pc);
        check(name, "mem_branch_taken", 32'(v.e_taken), 32'(mem_branch_taken));
        check(name, "mem_illegal_insn", 32'(v.e_illegal), 32'(mem_illegal_insn));
    endtask

    task automatic drive(input vec_t v);
        pc            <= v.pc;
        rs1_data      <= v.rs1;
        rs2_data      <= v.rs2;
        rd_mem_data   <= v.rd_mem;
        fwd_rs1       <= v.fwd1;
        fwd_rs2       <= v.fwd2;
        imm_i         <= v.imm_i;
        imm_s         <= v.imm_s;
        imm_sb        <= v.imm_sb;
        imm_uj        <= v.imm_uj;
        shamt         <= v.shamt;
        imm_u         <= v.imm_u;
        imm_shamt_sel <= v.shamt_sel;
        alu_a_sel     <= v.a_sel;
        alu_b_sel     <= v.b_sel;
        alu_op        <= v.op;
        branch_type   <= v.br;
        j_sel         <= v.j_sel;
        ex_pc_sel     <= v.pc_sel;
        reg_write     <= v.reg_write;
        rd            <= v.rd;
        illegal_insn  <= v.illegal;
        ex_mem_stall  <= v.stall;
        ex_mem_flush  <= v.flush;
        valid         <= v.valid;
    endtask

    task automatic build_table();
        vec_t          v;
        vec_t          held;
        ex_pkg::word_t neg_one;
        neg_one = 32'hffff_ffff;
        // alu ops on registers
        add_entry("add", alu_vec(ex_pkg::ALU_ADD, 32'd10, 32'd20, 32'd30));
        add_entry("sub", alu_vec(ex_pkg::ALU_SUB, 32'd5, 32'd7, 32'hffff_fffe));
        add_entry("and", alu_vec(ex_pkg::ALU_AND, 32'hf0f0_ff00, 32'h0ff0_f0f0, 32'h00f0_f000));
        add_entry("or", alu_vec(ex_pkg::ALU_OR, 32'hf0f0_ff00, 32'h0ff0_f0f0, 32'hfff0_fff0));
        add_entry("xor", alu_vec(ex_pkg::ALU_XOR, 32'hf0f0_ff00, 32'h0ff0_f0f0, 32'hff00_0ff0));
        // -2 against 1, signed vs unsigned
        add_entry("slt", alu_vec(ex_pkg::ALU_SLT, 32'hffff_fffe, 32'd1, 32'd1));
        add_entry("sltu", alu_vec(ex_pkg::ALU_SLTU, 32'hffff_fffe, 32'd1, 32'd0));
        // shamt replaces the i immediate and is zero-filled
        v = alu_vec(ex_pkg::ALU_ADD, 32'h100, 32'd0, 32'h0000_011f);
        v.b_sel     = ex_pkg::B_IMM_SHAMT;
        v.shamt_sel = 1'b1;
        v.shamt     = 5'h1f;
        v.imm_i     = 12'h800;
        add_entry("add_shamt", v);
        // shifts by zero-extended shamt
        v = alu_vec(ex_pkg::ALU_SLL, 32'h8000_0001, 32'd0, 32'h0000_0010);
        v.b_sel     = ex_pkg::B_IMM_SHAMT;
        v.shamt_sel = 1'b1;
        v.shamt     = 5'd4;
        add_entry("sll_shamt", v);
        v.rs1      = 32'h8000_0010;
        v.op       = ex_pkg::ALU_SRL;
        v.e_result = 32'h0800_0001;
        add_entry("srl_shamt", v);
        v.op       = ex_pkg::ALU_SRA;
        v.e_result = 32'hf800_0001;
        add_entry("sra_shamt", v);
        // other operand sources
        v = base_vec(32'h100);
        v.a_sel    = ex_pkg::A_PC;
        v.b_sel    = ex_pkg::B_IMM_U;
        v.imm_u    = 32'h1234_5000;
        v.e_result = 32'h1234_5100;
        add_entry("auipc", v);
        // -4 plus 2047 through the sign-extended i immediate
        v = base_vec(32'h100);
        v.a_sel    = ex_pkg::A_IMM_S;
        v.b_sel    = ex_pkg::B_IMM_SHAMT;
        v.imm_s    = 12'hffc;
        v.imm_i    = 12'h7ff;
        v.shamt    = 5'd31;
        v.e_result = 32'h0000_07fb;
        add_entry("imm_s_plus_imm_i", v);
        // zero operand a, every other a source would change the sum
        v = base_vec(32'h100);
        v.a_sel    = ex_pkg::A_ZERO;
        v.b_sel    = ex_pkg::B_RS1;
        v.rs1      = 32'hdead_beef;
        v.imm_s    = 12'h123;
        v.e_result = 32'hdead_beef;
        add_entry("zero_plus_rs1", v);
        // forwarding
        v = base_vec(32'h100);
        v.fwd1     = 1'b1;
        v.rd_mem   = 32'h1000;
        v.rs1      = 32'd1;
        v.rs2      = 32'd2;
        v.e_result = 32'h1002;
        add_entry("fwd_rs1", v);
        v.fwd1     = 1'b0;
        v.fwd2     = 1'b1;
        v.op       = ex_pkg::ALU_SUB;
        v.rd_mem   = 32'h50;
        v.e_result = 32'hffff_ffb1;
        add_entry("fwd_rs2", v);
        v.fwd1     = 1'b1;
        v.e_result = 32'd0;
        add_entry("fwd_both", v);
        // branches at 0x200, +16 gives 0x210, -16 gives 0x1f0
        add_entry("beq_taken",
                  branch_vec(ex_pkg::BR_EQ, 32'd7, 32'd7, 13'h0010, 32'd14, 1'b1, 32'h210));
        add_entry("beq_not_taken",
                  branch_vec(ex_pkg::BR_EQ, 32'd7, 32'd8, 13'h0010, 32'd15, 1'b0, 32'h204));
        add_entry("bne_taken",
                  branch_vec(ex_pkg::BR_NE, 32'd7, 32'd8, 13'h1ff0, 32'd15, 1'b1, 32'h1f0));
        add_entry("bne_not_taken",
                  branch_vec(ex_pkg::BR_NE, 32'd7, 32'd7, 13'h0010, 32'd14, 1'b0, 32'h204));
        add_entry("no_branch",
                  branch_vec(ex_pkg::BR_NONE, 32'd7, 32'd7, 13'h0010, 32'd14, 1'b0, 32'h204));
        add_entry("blt_taken_neg",
                  branch_vec(ex_pkg::BR_LT, neg_one, 32'd1, 13'h1ff0, 32'd0, 1'b1, 32'h1f0));
        add_entry("blt_not_taken",
                  branch_vec(ex_pkg::BR_LT, 32'd1, neg_one, 13'h0010, 32'd0, 1'b0, 32'h204));
        add_entry("bltu_taken",
                  branch_vec(ex_pkg::BR_LTU, 32'd1, neg_one, 13'h0010, 32'd0, 1'b1, 32'h210));
        add_entry("bltu_not_taken",
                  branch_vec(ex_pkg::BR_LTU, neg_one, 32'd1, 13'h1ff0, 32'd0, 1'b0, 32'h204));
        add_entry("bge_taken",
                  branch_vec(ex_pkg::BR_GE, 32'd1, neg_one, 13'h0010, 32'd0, 1'b1, 32'h210));
        add_entry("bge_equal",
                  branch_vec(ex_pkg::BR_GE, 32'd7, 32'd7, 13'h0010, 32'd14, 1'b1, 32'h210));
        add_entry("bge_not_taken",
                  branch_vec(ex_pkg::BR_GE, neg_one, 32'd1, 13'h1ff0, 32'd0, 1'b0, 32'h204));
        add_entry("bgeu_taken",
                  branch_vec(ex_pkg::BR_GEU, neg_one, 32'd1, 13'h1ff0, 32'd0, 1'b1, 32'h1f0));
        add_entry("bgeu_not_taken",
                  branch_vec(ex_pkg::BR_GEU, 32'd1, neg_one, 13'h0010, 32'd0, 1'b0, 32'h204));
        // jumps, link value pc + 4 through the alu
        v = base_vec(32'h300);
        v.a_sel    = ex_pkg::A_PC;
        v.b_sel    = ex_pkg::B_IMM_U;
        v.imm_u    = 32'd4;
        v.pc_sel   = 1'b1;
        v.j_sel    = 1'b1;
        v.imm_uj   = 21'h1f_fff0;
        v.e_result = 32'h304;
        v.e_brj    = 32'h2f0;
        add_entry("jal_back", v);
        v.j_sel = 1'b0;
        v.rs1   = 32'h1001;
        v.imm_i = 12'h004;
        v.e_brj = 32'h1004;
        add_entry("jalr_odd", v);
        v.rs1   = 32'h2000;
        v.imm_i = 12'hfff;
        v.e_brj = 32'h1ffe;
        add_entry("jalr_neg", v);
        // illegal taken branch loses its control bits
        v = branch_vec(ex_pkg::BR_EQ, 32'd7, 32'd7, 13'h0010, 32'd14, 1'b0, 32'h210);
        v.illegal     = 1'b1;
        v.e_reg_write = 1'b0;
        v.e_illegal   = 1'b1;
        add_entry("illegal_squash", v);
        // stall and flush sequence
        held = base_vec(32'h400);
        held.rs1      = 32'd3;
        held.rs2      = 32'd4;
        held.rd       = 5'd9;
        held.e_rd     = 5'd9;
        held.e_result = 32'd7;
        add_entry("pre_stall", held);
        v = held;
        v.pc    = 32'h500;
        v.rs1   = 32'd100;
        v.rd    = 5'd3;
        v.stall = 1'b1;
        add_entry("stall_hold", v);
        v.flush = 1'b1;
        add_entry("stall_flush_hold", v);
        v.stall       = 1'b0;
        v.e_valid     = 1'b0;
        v.e_reg_write = 1'b0;
        v.e_rd        = '0;
        v.e_result    = '0;
        v.e_brj       = '0;
        v.e_pc        = '0;
        add_entry("flush_clear", v);
    endtask

    initial begin
        vec_t rst_v;
        int   wait_cnt;
        drive('0);
        build_table();
        // register is cleared while reset is held
        @(posedge CLK);
        #1;
        rst_v = '0;
        check_outputs("reset", rst_v);
        // wait for reset release
        wait_cnt = 0;
        while (nRST !== 1'b1) begin
            @(posedge CLK);
            wait_cnt++;
            if (wait_cnt > 20) begin
                $display("reset was never released");
                $display("Test failed");
                $fatal(1, "timeout");
            end
        end
        foreach (table_q[i]) begin
            @(posedge CLK);
            drive(table_q[i]);
            @(posedge CLK);
            #1;
            check_outputs(names_q[i], table_q[i]);
        end
        $display("Test completed successfully");
        $finish;
    end

    // overall run limit
    initial begin
        #100000;
        $display("simulation ran past its time limit");
        $display("Test failed");
        $fatal(1, "timeout");
    end

endmodule

/* build.f */
source/ex_pkg.sv
source/operand_if.sv
source/ex_operand_sel.sv
source/ex_compute.sv
source/ex_mem_reg.sv
source/ex_stage_top.sv
test/ex_stage_props.sv
test/ex_stage_tb.sv

/* run.sh */
#!/usr/bin/env bash
# compile and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module ex_stage_tb \
    -f build.f \
    -o ex_stage_sim
if [ $? -ne 0 ]; then
    echo "compile step returned an error"
    exit 1
fi

./obj_dir/ex_stage_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "Test failed" "$LOG"; then
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "simulator exited with status $sim_status"
    exit 1
fi
exit 0
